//--- mem_patterns.txt
// columns: op addr wdata expect, all hex
// op 1 read, 2 write, 3 read with wr high, 4 byte_mode check (expect bit 0), 0 end
4 00 0000 0000  // word mode after reset
1 00 0000 5341  // rom signature
1 01 0000 5253
1 03 0000 144d
1 04 0000 3c14
1 4f 0000 160b
1 59 0000 0e00
1 5a 0000 000e
1 7f 0000 4100  // wraps to rom byte 0
1 ff 0000 0000  // config cleared
2 80 a1b2 0000
1 80 0000 a1b2
2 82 c3d4 0000
1 81 0000 d4a1
2 bf 1234 0000  // high byte wraps to ram byte 0
1 bf 0000 1234
1 80 0000 a112
2 ff 0001 0000  // byte mode on
4 00 0000 0001
1 ff 0000 0001
2 81 ffee 0000
1 81 0000 00ee
1 80 0000 0012
1 00 0000 0041
2 ff 0000 0000  // back to word mode
4 00 0000 0000
1 80 0000 ee12
1 82 0000 c3d4  // neighbour kept
2 ff 0002 0000  // ram locked
4 00 0000 0000
1 ff 0000 0002
2 80 5555 0000
1 80 0000 ee12
2 82 6666 0000
1 82 0000 c3d4
2 ff 0003 0000  // locked and byte mode
1 ff 0000 0003
4 00 0000 0001
2 81 7777 0000
1 81 0000 00ee
2 ff 0000 0000
4 00 0000 0000
2 00 ffff 0000  // rom writes ignored
1 00 0000 5341
2 7f 0000 0000
1 7f 0000 4100
1 c0 0000 0000  // unmapped
1 d5 0000 0000
1 fe 0000 0000
2 c0 1234 0000
1 c0 0000 0000
2 84 0102 0000
3 84 beef 0102  // collision, write dropped
1 84 0000 0102
3 ff 0001 0000
4 00 0000 0000
0 00 0000 0000

//--- src.f
mem_pkg.sv
rom_program.sv
ram_data.sv
mem_config.sv
mem_bus.sv
mem_subsystem.sv
tb_mem_subsystem.sv

//--- Bender.yml
package:
  name: mem_subsystem

sources:
  - mem_pkg.sv
  - rom_program.sv
  - ram_data.sv
  - mem_config.sv
  - mem_bus.sv
  - mem_subsystem.sv
  - target: test
    files:
      - tb_mem_subsystem.sv

//--- tb_mem_subsystem.sv
`timescale 1ns/100ps

module tb_mem_subsystem import mem_pkg::*; ();

  localparam int unsigned max_ops    = 64;  // pattern lines incl. end marker
  localparam int unsigned rd_timeout = 10;  // cycles

  // operation codes in the pattern file
  localparam logic [15:0] op_end   = 16'h0000;
  localparam logic [15:0] op_read  = 16'h0001;
  localparam logic [15:0] op_write = 16'h0002;
  localparam logic [15:0] op_both  = 16'h0003;  // rd and wr in one cycle
  localparam logic [15:0] op_mode  = 16'h0004;  // byte_mode level check

  logic              clk;
  logic              rst_n;
  logic [addr_w-1:0] addr;
  logic [data_w-1:0] wdata;
  logic              rd;
  logic              wr;
  logic [data_w-1:0] rdata;
  logic              rd_valid;
  logic              byte_mode;

  logic [15:0] pat [0:max_ops*4-1];  // four words per operation
  int          tests;
  int          errors;

  mem_subsystem DUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .addr      (addr),
    .wdata     (wdata),
    .rd        (rd),
    .wr        (wr),
    .rdata     (rdata),
    .rd_valid  (rd_valid),
    .byte_mode (byte_mode)
  );

  always #20 clk = ~clk;

  task automatic write_op(input logic [7:0] a, input logic [15:0] d);
    @(posedge clk);
    addr  <= a;
    wdata <= d;
    wr    <= 1'b1;
    @(posedge clk);  // write lands at this edge
    wr <= 1'b0;
  endtask

  // strobe rd, wait for rd_valid and compare; also_wr raises wr in the same cycle
  task automatic read_op(input logic [7:0] a, input logic [15:0] d,
                         input logic also_wr, input logic [15:0] exp);
    int waited;
    @(posedge clk);
    addr  <= a;
    wdata <= d;
    rd    <= 1'b1;
    wr    <= also_wr;
    @(posedge clk);  // strobe edge
    rd <= 1'b0;
    wr <= 1'b0;
    waited = 0;
    do begin
      @(negedge clk);  // sample away from the edges
      waited++;
    end while (!rd_valid && waited < rd_timeout);
    tests++;
    if (!rd_valid) begin
      errors++;
      $display("read at 0x%02h got no rd_valid within %0d cycles", a, rd_timeout);
    end else if (waited != 1) begin
      errors++;
      $display("Error: %0d ns: read at 0x%02h answered after %0d cycles, expected 1",
               $time, a, waited);
    end else if (rdata !== exp) begin
      errors++;
      $display("Error: %0d ns: read at 0x%02h returned 0x%04h, expected 0x%04h",
               $time, a, rdata, exp);
    end else begin
      @(negedge clk);  // rd_valid is a single-cycle pulse
      if (rd_valid !== 1'b0) begin
        errors++;
        $display("Error: %0d ns: read at 0x%02h kept rd_valid high a second cycle",
                 $time, a);
      end else begin
        $display("test %0d: read 0x%02h returned 0x%04h", tests, a, exp);
      end
    end
  endtask

  task automatic mode_op(input logic exp);
    @(negedge clk);
    tests++;
    if (byte_mode !== exp) begin
      errors++;
      $display("Error: %0d ns: byte_mode is %b, expected %b", $time, byte_mode, exp);
    end else begin
      $display("test %0d: byte_mode is %b", tests, byte_mode);
    end
  endtask

  initial begin
    int          op_idx;
    logic [15:0] op;
    logic [7:0]  a;
    logic [15:0] d;
    logic [15:0] e;

    clk    = 1'b0;
    rst_n  = 1'b0;
    addr   = '0;
    wdata  = '0;
    rd     = 1'b0;
    wr     = 1'b0;
    tests  = 0;
    errors = 0;

    for (op_idx = 0; op_idx < max_ops*4; op_idx++) begin
      pat[op_idx] = '0;
    end
    $readmemh("mem_patterns.txt", pat);

    repeat (2) @(posedge clk);  // reset held for two cycles
    rst_n <= 1'b1;

    // idle state right after reset
    @(negedge clk);
    tests++;
    if (rd_valid !== 1'b0 || rdata !== 16'h0000 || byte_mode !== 1'b0) begin
      errors++;
      $display("Error: %0d ns: after reset rd_valid=%b rdata=0x%04h byte_mode=%b",
               $time, rd_valid, rdata, byte_mode);
    end else begin
      $display("test %0d: reset state", tests);
    end

    if (pat[0] == op_end) begin
      errors++;
      $display("no operations were loaded from mem_patterns.txt");
    end

    op_idx = 0;
    while (op_idx < max_ops && pat[op_idx*4] != op_end) begin
      op = pat[op_idx*4];
      a  = pat[op_idx*4+1][7:0];
      d  = pat[op_idx*4+2];
      e  = pat[op_idx*4+3];
      case (op)
        op_read:  read_op(a, d, 1'b0, e);
        op_write: write_op(a, d);
        op_both:  read_op(a, d, 1'b1, e);
        op_mode:  mode_op(e[0]);
        default: begin
          errors++;
          $display("pattern line %0d has an unknown operation code %0h", op_idx, op);
        end
      endcase
      op_idx++;
    end

    $display("tests run: %0d, errors: %0d", tests, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

//--- mem_subsystem.sv
`timescale 1ns/100ps

module mem_subsystem import mem_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  input  logic [addr_w-1:0] addr,
  input  logic [data_w-1:0] wdata,
  input  logic              rd,
  input  logic              wr,
  output logic [data_w-1:0] rdata,
  output logic              rd_valid,
  output logic              byte_mode
);

  logic [rom_aw-1:0] rom_addr;
  logic              rom_en;
  mem_word_u         rom_data;
  logic [ram_aw-1:0] ram_addr;
  mem_word_u         ram_wdata;
  logic              ram_we_lo;
  logic              ram_we_hi;
  logic              ram_en;
  mem_word_u         ram_data;
  logic              cfg_we;
  logic [7:0]        cfg_wdata;
  logic [7:0]        cfg_value;
  logic              ram_lock;

  mem_bus u_bus (
    .clk       (clk),
    .rst_n     (rst_n),
    .addr      (addr),
    .wdata     (wdata),
    .rd        (rd),
    .wr        (wr),
    .rdata     (rdata),
    .rd_valid  (rd_valid),
    .rom_addr  (rom_addr),
    .rom_en    (rom_en),
    .rom_data  (rom_data),
    .ram_addr  (ram_addr),
    .ram_wdata (ram_wdata),
    .ram_we_lo (ram_we_lo),
    .ram_we_hi (ram_we_hi),
    .ram_en    (ram_en),
    .ram_data  (ram_data),
    .cfg_we    (cfg_we),
    .cfg_wdata (cfg_wdata),
    .cfg_value (cfg_value),
    .byte_mode (byte_mode),
    .ram_lock  (ram_lock)
  );

  rom_program u_rom (
    .clk      (clk),
    .rom_en   (rom_en),
    .rom_addr (rom_addr),
    .rom_data (rom_data)
  );

  ram_data u_ram (
    .clk       (clk),
    .ram_en    (ram_en),
    .ram_addr  (ram_addr),
    .ram_wdata (ram_wdata),
    .ram_we_lo (ram_we_lo),
    .ram_we_hi (ram_we_hi),
    .ram_data  (ram_data)
  );

  mem_config u_cfg (
    .clk       (clk),
    .rst_n     (rst_n),
    .cfg_we    (cfg_we),
    .cfg_wdata (cfg_wdata),
    .cfg_value (cfg_value),
    .byte_mode (byte_mode),  // also a status level for the core
    .ram_lock  (ram_lock)
  );

endmodule

//--- mem_bus.sv
`timescale 1ns/100ps

module mem_bus import mem_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  input  logic [addr_w-1:0] addr,
  input  logic [data_w-1:0] wdata,
  input  logic              rd,
  input  logic              wr,
  output logic [data_w-1:0] rdata,
  output logic              rd_valid,
  output logic [rom_aw-1:0] rom_addr,
  output logic              rom_en,
  input  mem_word_u         rom_data,
  output logic [ram_aw-1:0] ram_addr,
  output mem_word_u         ram_wdata,
  output logic              ram_we_lo,
  output logic              ram_we_hi,
  output logic              ram_en,
  input  mem_word_u         ram_data,
  output logic              cfg_we,
  output logic [7:0]        cfg_wdata,
  input  logic [7:0]        cfg_value,
  input  logic              byte_mode,
  input  logic              ram_lock
);

  logic [addr_w-1:0] rom_off;
  logic [addr_w-1:0] ram_off;
  logic              rom_hit;
  logic              ram_hit;
  logic              cfg_hit;
  logic              wr_ok;
  mem_word_u         wdata_u;
  logic              sel_rom_q;
  logic              sel_ram_q;
  logic              sel_cfg_q;
  logic              byte_q;
  mem_word_u         resp;

  // region decode by offset from each base
  assign rom_off = addr - rom_base;
  assign ram_off = addr - ram_base;
  assign rom_hit = (rom_off < rom_size);
  assign ram_hit = (ram_off < ram_size);
  assign cfg_hit = (addr == cfg_addr);

  assign wr_ok = wr & ~rd;  // read wins a collision

  assign rom_addr = rom_off[rom_aw-1:0];
  assign ram_addr = ram_off[ram_aw-1:0];
  assign rom_en   = rd & rom_hit;
  assign ram_en   = rd & ram_hit;

  always_comb begin
    wdata_u.word = wdata;
    ram_wdata    = wdata_u;
    cfg_wdata    = wdata_u.lane[0];
    ram_we_lo    = wr_ok & ram_hit & ~ram_lock;  // locked ram ignores writes
    ram_we_hi    = ram_we_lo & ~byte_mode;       // high lane only in word mode
    cfg_we       = wr_ok & cfg_hit;
  end

  // remember where each read went and in which mode
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_valid  <= 1'b0;
      sel_rom_q <= 1'b0;
      sel_ram_q <= 1'b0;
      sel_cfg_q <= 1'b0;
      byte_q    <= 1'b0;
    end else begin
      rd_valid  <= rd;
      sel_rom_q <= rom_en;
      sel_ram_q <= ram_en;
      sel_cfg_q <= rd & cfg_hit;
      byte_q    <= byte_mode;  // mode at the strobe edge
    end
  end

  // response mux over the memory output registers
  always_comb begin
    resp = '0;  // unmapped reads return zero
    if (sel_rom_q) begin
      resp = rom_data;
    end else if (sel_ram_q) begin
      resp = ram_data;
    end else if (sel_cfg_q) begin
      resp.lane[0] = cfg_value;
    end
    if (byte_q) begin
      resp.lane[1] = 8'h00;  // single byte in byte mode
    end
  end

  assign rdata = resp.word;

endmodule

//--- mem_config.sv
`timescale 1ns/100ps

module mem_config import mem_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       cfg_we,
  input  logic [7:0] cfg_wdata,
  output logic [7:0] cfg_value,
  output logic       byte_mode,
  output logic       ram_lock
);

  // only the two defined bits are stored
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      byte_mode <= 1'b0;  // word mode after reset
      ram_lock  <= 1'b0;
    end else if (cfg_we) begin
      byte_mode <= cfg_wdata[cfg_byte_mode_bit];
      ram_lock  <= cfg_wdata[cfg_ram_lock_bit];
    end
  end

  always_comb begin
    cfg_value                    = '0;  // undefined bits read zero
    cfg_value[cfg_byte_mode_bit] = byte_mode;
    cfg_value[cfg_ram_lock_bit]  = ram_lock;
  end

endmodule

//--- ram_data.sv
`timescale 1ns/100ps

module ram_data import mem_pkg::*; (
  input  logic              clk,
  input  logic              ram_en,
  input  logic [ram_aw-1:0] ram_addr,
  input  mem_word_u         ram_wdata,
  input  logic              ram_we_lo,
  input  logic              ram_we_hi,
  output mem_word_u         ram_data
);

  logic [7:0]        mem [ram_size];
  logic [ram_aw-1:0] ram_addr_nx;

  assign ram_addr_nx = ram_addr + 1'b1;  // wraps inside the ram

  // byte lanes written independently
  always_ff @(posedge clk) begin
    if (ram_we_lo) begin
      mem[ram_addr] <= ram_wdata.lane[0];
    end
    if (ram_we_hi) begin
      mem[ram_addr_nx] <= ram_wdata.lane[1];
    end
  end

  always_ff @(posedge clk) begin
    if (ram_en) begin
      ram_data.lane[0] <= mem[ram_addr];
      ram_data.lane[1] <= mem[ram_addr_nx];  // byte at a+1
    end
  end

endmodule

//--- rom_program.sv
`timescale 1ns/100ps

module rom_program import mem_pkg::*; (
  input  logic              clk,
  input  logic              rom_en,
  input  logic [rom_aw-1:0] rom_addr,
  output mem_word_u         rom_data
);

  logic [rom_aw-1:0] rom_addr_nx;

  function automatic logic [7:0] rom_byte(input logic [rom_aw-1:0] a);
    case (a)
      7'h00: rom_byte = 8'h41;  // runtime signature
      7'h01: rom_byte = 8'h53;
      7'h02: rom_byte = 8'h52;
      7'h03: rom_byte = 8'h4d;
      7'h04: rom_byte = 8'h14;  // runtime setup
      7'h05: rom_byte = 8'h3c;
      7'h06: rom_byte = 8'h10;
      7'h07: rom_byte = 8'h3b;
      7'h08: rom_byte = 8'h10;
      7'h09: rom_byte = 8'h7b;
      7'h0a: rom_byte = 8'hac;
      7'h0b: rom_byte = 8'h3b;
      7'h0c: rom_byte = 8'h10;
      7'h0d: rom_byte = 8'h7b;
      7'h0e: rom_byte = 8'hac;
      7'h0f: rom_byte = 8'h3b;
      7'h10: rom_byte = 8'h15;
      7'h11: rom_byte = 8'h7b;
      7'h12: rom_byte = 8'hac;
      7'h13: rom_byte = 8'h3b;
      7'h14: rom_byte = 8'h1b;
      7'h15: rom_byte = 8'h7b;
      7'h16: rom_byte = 8'h3f;
      7'h17: rom_byte = 8'h14;
      7'h18: rom_byte = 8'h3c;
      7'h19: rom_byte = 8'h10;
      7'h1a: rom_byte = 8'h3b;
      7'h1b: rom_byte = 8'h10;
      7'h1c: rom_byte = 8'h7b;
      7'h1d: rom_byte = 8'hac;
      7'h1e: rom_byte = 8'h3b;
      7'h1f: rom_byte = 8'h10;
      7'h20: rom_byte = 8'h7b;
      7'h21: rom_byte = 8'hac;
      7'h22: rom_byte = 8'h3b;
      7'h23: rom_byte = 8'h12;
      7'h24: rom_byte = 8'h7b;
      7'h25: rom_byte = 8'hac;
      7'h26: rom_byte = 8'h3b;
      7'h27: rom_byte = 8'h1a;
      7'h28: rom_byte = 8'h7b;
      7'h29: rom_byte = 8'h3e;
      7'h2a: rom_byte = 8'h14;  // program entry
      7'h2b: rom_byte = 8'h3c;
      7'h2c: rom_byte = 8'h10;
      7'h2d: rom_byte = 8'h3b;
      7'h2e: rom_byte = 8'h19;
      7'h2f: rom_byte = 8'h7b;
      7'h30: rom_byte = 8'hac;
      7'h31: rom_byte = 8'h3b;
      7'h32: rom_byte = 8'h1c;
      7'h33: rom_byte = 8'h7b;
      7'h34: rom_byte = 8'hac;
      7'h35: rom_byte = 8'h3b;
      7'h36: rom_byte = 8'h14;
      7'h37: rom_byte = 8'h7b;
      7'h38: rom_byte = 8'hac;
      7'h39: rom_byte = 8'h3b;
      7'h3a: rom_byte = 8'h10;
      7'h3b: rom_byte = 8'h7b;
      7'h3c: rom_byte = 8'h3f;
      7'h3d: rom_byte = 8'h14;  // stack pointer load
      7'h3e: rom_byte = 8'h3c;  // build the 0xabcd constant
      7'h3f: rom_byte = 8'h10;
      7'h40: rom_byte = 8'h3b;
      7'h41: rom_byte = 8'h1a;
      7'h42: rom_byte = 8'h7b;
      7'h43: rom_byte = 8'hac;
      7'h44: rom_byte = 8'h3b;
      7'h45: rom_byte = 8'h1b;
      7'h46: rom_byte = 8'h7b;
      7'h47: rom_byte = 8'hac;
      7'h48: rom_byte = 8'h3b;
      7'h49: rom_byte = 8'h1c;
      7'h4a: rom_byte = 8'h7b;
      7'h4b: rom_byte = 8'hac;
      7'h4c: rom_byte = 8'h3b;
      7'h4d: rom_byte = 8'h1d;
      7'h4e: rom_byte = 8'h7b;
      7'h4f: rom_byte = 8'h0b;  // save word
      7'h50: rom_byte = 8'h16;  // status bits on
      7'h51: rom_byte = 8'h3d;
      7'h52: rom_byte = 8'h10;
      7'h53: rom_byte = 8'h0a;  // restore in reduced mode
      7'h54: rom_byte = 8'h13;
      7'h55: rom_byte = 8'h0b;
      7'h56: rom_byte = 8'h10;  // status bits off
      7'h57: rom_byte = 8'h3d;
      7'h58: rom_byte = 8'h0a;
      7'h59: rom_byte = 8'h00;  // sleep
      7'h5a: rom_byte = 8'h0e;  // quit
      default: rom_byte = 8'h00;
    endcase
  endfunction

  assign rom_addr_nx = rom_addr + 1'b1;  // wraps inside the rom

  // even/odd lane pair read in one edge
  always_ff @(posedge clk) begin
    if (rom_en) begin
      rom_data.lane[0] <= rom_byte(rom_addr);
      rom_data.lane[1] <= rom_byte(rom_addr_nx);
    end
  end

endmodule

//--- mem_pkg.sv
package mem_pkg;

  localparam int unsigned addr_w = 8;   // byte address of the master
  localparam int unsigned data_w = 16;  // little-endian word

  localparam logic [addr_w-1:0] rom_base = 8'h00;
  localparam int unsigned       rom_size = 128;  // bytes
  localparam int unsigned       rom_aw   = $clog2(rom_size);

  localparam logic [addr_w-1:0] ram_base = 8'h80;
  localparam int unsigned       ram_size = 64;   // bytes
  localparam int unsigned       ram_aw   = $clog2(ram_size);

  localparam logic [addr_w-1:0] cfg_addr = 8'hff;

  // reduced-behavior bits in the config byte
  localparam int unsigned cfg_byte_mode_bit = 0;
  localparam int unsigned cfg_ram_lock_bit  = 1;

  typedef union packed {
    logic [data_w-1:0] word;
    logic [1:0][7:0]   lane;  // lane[0] is the byte at a
  } mem_word_u;

endpackage
